/* Bender.yml */
package:
  name: soc_bus

sources:
  - soc_pkg.sv
  - bus_decode.sv
  - bus_ram.sv
  - bus_timer.sv
  - bus_return.sv
  - soc_bus_top.sv
  - target: test
    files:
      - tb_bus_checker.sv
      - tb_soc_bus.sv

/* bus_decode.sv */
`timescale 1ns/1ps

module bus_decode
(
	input logic i_request,
	input soc_pkg::bus_req_t i_req,
	output soc_pkg::bus_select_t o_select,
	output soc_pkg::bus_addr_t o_offset
);

	logic [3:0] region;
	logic hit_ram;
	logic hit_timer;

	// ==================================================
	// Region match
	// ==================================================

	// Top nibble picks the target
	assign region = i_req.address[31:28];

	assign hit_ram = (region == soc_pkg::REGION_RAM);
	assign hit_timer = (region == soc_pkg::REGION_TIMER);

	assign o_select.ram = hit_ram;
	assign o_select.timer = hit_timer;

	// Anything outside the map goes to the error responder
	assign o_select.none = !(hit_ram || hit_timer);

	// ==================================================
	// Local address
	// ==================================================

	// Region bits stripped, targets see a byte offset from their base
	assign o_offset = {4'h0, i_req.address[27:0]};

	// Address is held for the whole access, so check it as request drops
	a_select_onehot : assert property (
		@(negedge i_request)
		i_request |-> $onehot(o_select)
	);

endmodule

/* bus_ram.sv */
`timescale 1ns/1ps

module bus_ram
#(
	parameter int RAM_WORDS = 1024
)
(
	input logic clock,
	input logic i_arst_n,
	input logic i_request,
	input logic i_select,
	input logic i_rw,
	input soc_pkg::bus_addr_t i_offset,
	input soc_pkg::bus_data_t i_wdata,
	output soc_pkg::bus_rsp_t o_rsp
);

	localparam int INDEX_W = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;

	soc_pkg::bus_data_t mem [RAM_WORDS];
	soc_pkg::bus_data_t rdata_q;
	logic [INDEX_W-1:0] word_index;
	logic busy_q;
	logic ready_q;
	logic accept;

	// Byte offset to word index, wrapping past the last word
	assign word_index = INDEX_W'((i_offset >> 2) % RAM_WORDS);

	// First cycle of a request to this RAM
	assign accept = i_request && i_select && !busy_q;

	// Storage and registered read port
	always_ff @(posedge clock)
	begin
		if (accept)
		begin
			if (i_rw)
				mem[word_index] <= i_wdata;
			rdata_q <= mem[word_index];
		end
	end

	// One ready pulse per request
	always_ff @(posedge clock or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			busy_q <= 1'b0;
			ready_q <= 1'b0;
		end
		else
		begin
			ready_q <= accept;
			if (accept)
				busy_q <= 1'b1;
			else if (!i_request)
				busy_q <= 1'b0;
		end
	end

	assign o_rsp.rdata = rdata_q;
	assign o_rsp.ready = ready_q;

	a_ready_single : assert property (
		@(posedge clock) disable iff (!i_arst_n)
		ready_q |=> !ready_q
	);

endmodule

/* bus_return.sv */
`timescale 1ns/1ps

module bus_return
(
	input logic clock,
	input logic i_arst_n,
	input logic i_request,
	input soc_pkg::bus_select_t i_select,
	input soc_pkg::bus_rsp_t i_ram_rsp,
	input soc_pkg::bus_rsp_t i_timer_rsp,
	output soc_pkg::bus_rsp_t o_rsp,
	output logic o_error
);

	logic none_busy_q;
	logic none_ready_q;
	logic none_accept;

	// Unmapped access answered here so the master never stalls
	assign none_accept = i_request && i_select.none && !none_busy_q;

	always_ff @(posedge clock or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			none_busy_q <= 1'b0;
			none_ready_q <= 1'b0;
		end
		else
		begin
			none_ready_q <= none_accept;
			if (none_accept)
				none_busy_q <= 1'b1;
			else if (!i_request)
				none_busy_q <= 1'b0;
		end
	end

	// Response from whichever target the address selects
	always_comb
	begin
		o_rsp = '0;
		if (i_select.ram)
			o_rsp = i_ram_rsp;
		else if (i_select.timer)
			o_rsp = i_timer_rsp;
		else if (i_select.none)
			o_rsp.ready = none_ready_q;
	end

	assign o_error = none_ready_q;

endmodule

/* bus_timer.sv */
`timescale 1ns/1ps

module bus_timer
#(
	parameter int TIMER_PRESCALE = 4
)
(
	input logic clock,
	input logic i_arst_n,
	input logic i_request,
	input logic i_select,
	input logic i_rw,
	input soc_pkg::bus_addr_t i_offset,
	input soc_pkg::bus_data_t i_wdata,
	output soc_pkg::bus_rsp_t o_rsp,
	output logic o_interrupt
);

	localparam int PRESCALE_W = $clog2(TIMER_PRESCALE + 1);

	logic [PRESCALE_W-1:0] prescale_q;
	soc_pkg::bus_data_t count_q;
	soc_pkg::bus_data_t compare_q;
	soc_pkg::bus_data_t read_value;
	soc_pkg::bus_data_t rdata_q;
	soc_pkg::timer_reg_t reg_index;
	logic enable_q;
	logic pending_q;
	logic busy_q;
	logic ready_q;
	logic accept;
	logic write;
	logic tick;
	logic match;
	logic clear;

	assign reg_index = i_offset[3:2];
	assign accept = i_request && i_select && !busy_q;
	assign write = accept && i_rw;

	// Counter step every TIMER_PRESCALE clocks while enabled
	assign tick = enable_q && (prescale_q == PRESCALE_W'(TIMER_PRESCALE - 1));
	assign match = enable_q && (count_q == compare_q);
	// Write-one to control bit 1 acknowledges the interrupt
	assign clear = write && (reg_index == soc_pkg::TIMER_REG_CONTROL) && i_wdata[1];

	always_comb
	begin
		case (reg_index)
			soc_pkg::TIMER_REG_COUNT: read_value = count_q;
			soc_pkg::TIMER_REG_COMPARE: read_value = compare_q;
			soc_pkg::TIMER_REG_CONTROL: read_value = {30'd0, pending_q, enable_q};
			default: read_value = '0;
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (accept)
			rdata_q <= read_value;
	end

	// ==================================================
	// Registers
	// ==================================================

	always_ff @(posedge clock or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			prescale_q <= '0;
			count_q <= '0;
			compare_q <= '0;
			enable_q <= 1'b0;
			pending_q <= 1'b0;
			busy_q <= 1'b0;
			ready_q <= 1'b0;
		end
		else
		begin
			ready_q <= accept;
			if (accept)
				busy_q <= 1'b1;
			else if (!i_request)
				busy_q <= 1'b0;

			// Counter load restarts the prescaler too
			if (write && reg_index == soc_pkg::TIMER_REG_COUNT)
			begin
				count_q <= i_wdata;
				prescale_q <= '0;
			end
			else if (tick)
			begin
				count_q <= count_q + 1'b1;
				prescale_q <= '0;
			end
			else if (enable_q)
				prescale_q <= prescale_q + 1'b1;
			else
				prescale_q <= '0;

			if (write && reg_index == soc_pkg::TIMER_REG_COMPARE)
				compare_q <= i_wdata;
			if (write && reg_index == soc_pkg::TIMER_REG_CONTROL)
				enable_q <= i_wdata[0];

			if (clear)
				pending_q <= 1'b0;
			else if (match)
				pending_q <= 1'b1;
		end
	end

	assign o_rsp.rdata = rdata_q;
	assign o_rsp.ready = ready_q;
	assign o_interrupt = pending_q;

	// No interrupt appears without a preceding compare match
	a_irq_needs_match : assert property (
		@(posedge clock) disable iff (!i_arst_n)
		!pending_q && !match |=> !o_interrupt
	);

endmodule

/* soc_bus_patterns.txt */
# op  address  data  expected  mask  error  name (all numbers hex)
# data: write word, random-fill word count, or interrupt level (0, 1, f any) for read and poll
write 10000010 deadbeef 0 0 0 ram_write_word
read 10000010 f deadbeef ffffffff 0 ram_read_word
write 10000000 a5a50001 0 0 0 ram_write_word0
read 10001000 f a5a50001 ffffffff 0 ram_offset_wrap
random-fill 10000100 10 0 0 0 ram_random_fill
read 30000000 f 0 ffffffff 1 unmapped_read
write 50000000 1234 0 0 1 unmapped_write
read 10000010 f deadbeef ffffffff 0 mapped_after_error
write a0000004 12345678 0 0 0 timer_compare_write
read a0000004 f 12345678 ffffffff 0 timer_compare_read
write a0000008 fffffff1 0 0 0 timer_control_write
read a0000008 0 1 ffffffff 0 timer_control_read
write a0000008 0 0 0 0 timer_disable
write a0000000 0 0 0 0 timer_count_zero
write a0000004 3 0 0 0 timer_compare_small
write a0000008 1 0 0 0 timer_enable
poll a0000008 1 2 2 0 timer_poll_pending
write a0000000 0 0 0 0 timer_count_reload
write a0000008 2 0 0 0 timer_clear_pending
read a0000008 0 0 ffffffff 0 timer_control_cleared

/* soc_bus_top.sv */
`timescale 1ns/1ps

module soc_bus_top
#(
	parameter int RAM_WORDS = 1024,
	parameter int TIMER_PRESCALE = 4
)
(
	input logic clock,
	input logic i_arst_n,
	input logic i_request,
	input soc_pkg::bus_req_t i_req,
	output soc_pkg::bus_rsp_t o_rsp,
	output logic o_error,
	output logic o_interrupt
);

	soc_pkg::bus_select_t select;
	soc_pkg::bus_addr_t offset;
	soc_pkg::bus_rsp_t ram_rsp;
	soc_pkg::bus_rsp_t timer_rsp;

	// ==================================================
	// Address decode
	// ==================================================

	bus_decode u_decode (
		.i_request(i_request),
		.i_req(i_req),
		.o_select(select),
		.o_offset(offset)
	);

	// ==================================================
	// Targets
	// ==================================================

	// RAM at region 1
	bus_ram #(
		.RAM_WORDS(RAM_WORDS)
	) u_ram (
		.clock(clock),
		.i_arst_n(i_arst_n),
		.i_request(i_request),
		.i_select(select.ram),
		.i_rw(i_req.rw),
		.i_offset(offset),
		.i_wdata(i_req.wdata),
		.o_rsp(ram_rsp)
	);

	// Timer at region A
	bus_timer #(
		.TIMER_PRESCALE(TIMER_PRESCALE)
	) u_timer (
		.clock(clock),
		.i_arst_n(i_arst_n),
		.i_request(i_request),
		.i_select(select.timer),
		.i_rw(i_req.rw),
		.i_offset(offset),
		.i_wdata(i_req.wdata),
		.o_rsp(timer_rsp),
		.o_interrupt(o_interrupt)
	);

	// Return path back to the master
	bus_return u_return (
		.clock(clock),
		.i_arst_n(i_arst_n),
		.i_request(i_request),
		.i_select(select),
		.i_ram_rsp(ram_rsp),
		.i_timer_rsp(timer_rsp),
		.o_rsp(o_rsp),
		.o_error(o_error)
	);

endmodule

/* soc_pkg.sv */
package soc_pkg;

	// ==================================================
	// Bus word types
	// ==================================================

	// Byte address as issued by the master
	typedef logic [31:0] bus_addr_t;

	typedef logic [31:0] bus_data_t;

	// Word register index inside the timer block
	typedef logic [1:0] timer_reg_t;

	// ==================================================
	// Request and response bundles
	// ==================================================

	// Master side, rw high means write
	typedef struct packed {
		logic rw;
		bus_addr_t address;
		bus_data_t wdata;
	} bus_req_t;

	// Target side, rdata valid together with ready
	typedef struct packed {
		bus_data_t rdata;
		logic ready;
	} bus_rsp_t;

	// One-hot target select
	typedef struct packed {
		logic ram;
		logic timer;
		logic none;
	} bus_select_t;

	// ==================================================
	// Address map
	// ==================================================

	// Top address nibble of each region
	localparam logic [3:0] REGION_RAM = 4'h1;
	localparam logic [3:0] REGION_TIMER = 4'hA;

	// Timer registers, one word apart
	localparam timer_reg_t TIMER_REG_COUNT = 2'd0;
	localparam timer_reg_t TIMER_REG_COMPARE = 2'd1;
	localparam timer_reg_t TIMER_REG_CONTROL = 2'd2;

endpackage

/* tb_bus_checker.sv */
`timescale 1ns/1ps

module tb_bus_checker
(
	input logic clock,
	input logic i_arst_n,
	input soc_pkg::bus_rsp_t i_rsp,
	input logic i_error,
	input logic i_interrupt
);

	string test_name;
	soc_pkg::bus_data_t exp_data;
	soc_pkg::bus_data_t exp_mask;
	logic exp_error;
	logic irq_check;
	logic exp_irq;
	logic armed;
	int pass_count;
	int fail_count;

	initial
	begin
		armed = 1'b0;
		pass_count = 0;
		fail_count = 0;
	end

	// Expected outcome of the next ready cycle
	task arm(input string name, input logic [31:0] data, input logic [31:0] mask,
		input logic err, input logic check_irq, input logic irq);
		begin
			test_name = name;
			exp_data = data;
			exp_mask = mask;
			exp_error = err;
			irq_check = check_irq;
			exp_irq = irq;
			armed = 1'b1;
		end
	endtask

	task note_failure(input string name, input string reason);
		begin
			$display("fail %s: %s", name, reason);
			fail_count++;
		end
	endtask

	// ==================================================
	// Response compare
	// ==================================================

	// Sampled mid-cycle, away from the clock edge
	always @(negedge clock)
	begin
		if (i_arst_n && armed && i_rsp.ready)
		begin
			armed = 1'b0;
			if ((i_rsp.rdata & exp_mask) !== (exp_data & exp_mask) || i_error !== exp_error)
			begin
				$display("mismatch %s: expected rdata %h error %b, actual rdata %h error %b",
					test_name, exp_data & exp_mask, exp_error,
					i_rsp.rdata & exp_mask, i_error);
				fail_count++;
			end
			else if (irq_check && i_interrupt !== exp_irq)
			begin
				$display("mismatch %s: expected interrupt %b, actual interrupt %b",
					test_name, exp_irq, i_interrupt);
				fail_count++;
			end
			else
			begin
				$display("pass %s", test_name);
				pass_count++;
			end
		end
	end

endmodule

/* tb_soc_bus.sv */
`timescale 1ns/1ps

module tb_soc_bus;

	localparam int RAM_WORDS = 1024;
	localparam int TIMER_PRESCALE = 4;
	localparam int CLOCK_PERIOD = 100;
	localparam int POLL_LIMIT = 20;
	localparam logic [31:0] LFSR_SEED = 32'h8b0a90fe;

	logic clock;
	logic i_arst_n;
	logic bus_request;
	soc_pkg::bus_req_t bus_req;
	soc_pkg::bus_rsp_t bus_rsp;
	logic bus_error;
	logic bus_irq;
	logic [31:0] lfsr_state;
	logic [31:0] last_rdata;
	logic [31:0] fill_words [256];
	logic load_done;
	logic load_ok;
	int n_lines;
	string op_q[$];
	string name_q[$];
	logic [31:0] addr_q[$];
	logic [31:0] data_q[$];
	logic [31:0] exp_q[$];
	logic [31:0] mask_q[$];
	logic err_q[$];

	soc_bus_top #(
		.RAM_WORDS(RAM_WORDS),
		.TIMER_PRESCALE(TIMER_PRESCALE)
	) i_dut (
		.clock(clock),
		.i_arst_n(i_arst_n),
		.i_request(bus_request),
		.i_req(bus_req),
		.o_rsp(bus_rsp),
		.o_error(bus_error),
		.o_interrupt(bus_irq)
	);

	tb_bus_checker u_checker (
		.clock(clock),
		.i_arst_n(i_arst_n),
		.i_rsp(bus_rsp),
		.i_error(bus_error),
		.i_interrupt(bus_irq)
	);

	always #(CLOCK_PERIOD / 2) clock = ~clock;

	// Galois form, feedback taps x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		logic [31:0] next;
		begin
			next = state >> 1;
			if (state[0])
				next = next ^ 32'h80200003;
			return next;
		end
	endfunction

	task next_random_word(output logic [31:0] word);
		int b;
		begin
			for (b = 0; b < 32; b++)
			begin
				lfsr_state = lfsr_step(lfsr_state);
				word[b] = lfsr_state[0];
			end
		end
	endtask

	// ==================================================
	// Pattern file
	// ==================================================

	task load_patterns(output logic ok);
		int fd;
		int fields;
		string line;
		string op;
		string name;
		logic [31:0] addr;
		logic [31:0] data;
		logic [31:0] expv;
		logic [31:0] mask;
		logic [31:0] err;
		begin
			ok = 1'b1;
			fd = $fopen("soc_bus_patterns.txt", "r");
			if (fd == 0)
				ok = 1'b0;
			while (ok && !$feof(fd))
			begin
				line = "";
				void'($fgets(line, fd));
				// Skip comments and blank lines
				if (line.len() > 1 && line.getc(0) != "#")
				begin
					fields = $sscanf(line, "%s %h %h %h %h %h %s",
						op, addr, data, expv, mask, err, name);
					if (fields == 7)
					begin
						op_q.push_back(op);
						addr_q.push_back(addr);
						data_q.push_back(data);
						exp_q.push_back(expv);
						mask_q.push_back(mask);
						err_q.push_back(err[0]);
						name_q.push_back(name);
					end
					else
					begin
						$display("malformed pattern line: %s", line);
						ok = 1'b0;
					end
				end
			end
			if (fd != 0)
				$fclose(fd);
			n_lines = op_q.size();
			if (n_lines == 0)
				ok = 1'b0;
		end
	endtask

	// ==================================================
	// Bus driver
	// ==================================================

	// One complete access, inputs change 5 ns after the rising edge
	task bus_access(input logic rw, input logic [31:0] addr, input logic [31:0] wdata);
		begin
			@(posedge clock);
			#5;
			bus_req.rw = rw;
			bus_req.address = addr;
			bus_req.wdata = wdata;
			bus_request = 1'b1;
			@(negedge clock);
			while (!bus_rsp.ready)
				@(negedge clock);
			last_rdata = bus_rsp.rdata;
			@(posedge clock);
			#5;
			bus_request = 1'b0;
		end
	endtask

	task run_pattern(input int i);
		int polls;
		int w;
		logic hit;
		logic [31:0] word;
		logic check_irq;
		begin
			// For reads the data column is the interrupt level, F means any
			check_irq = (data_q[i] <= 32'd1);
			if (op_q[i] == "write")
			begin
				u_checker.arm(name_q[i], '0, '0, err_q[i], 1'b0, 1'b0);
				bus_access(1'b1, addr_q[i], data_q[i]);
			end
			else if (op_q[i] == "read")
			begin
				u_checker.arm(name_q[i], exp_q[i], mask_q[i], err_q[i], check_irq, data_q[i][0]);
				bus_access(1'b0, addr_q[i], '0);
			end
			else if (op_q[i] == "poll")
			begin
				hit = 1'b0;
				for (polls = 0; polls < POLL_LIMIT && !hit; polls++)
				begin
					bus_access(1'b0, addr_q[i], '0);
					hit = ((last_rdata & mask_q[i]) == (exp_q[i] & mask_q[i]));
				end
				if (hit)
				begin
					u_checker.arm(name_q[i], exp_q[i], mask_q[i], err_q[i],
						check_irq, data_q[i][0]);
					bus_access(1'b0, addr_q[i], '0);
				end
				else
					u_checker.note_failure(name_q[i], "register never matched within the poll limit");
			end
			else if (op_q[i] == "random-fill")
			begin
				for (w = 0; w < data_q[i] && w < 256; w++)
				begin
					next_random_word(word);
					fill_words[w] = word;
					bus_access(1'b1, addr_q[i] + 32'(w * 4), word);
				end
				// Read back last word first
				for (w = w - 1; w >= 0; w--)
				begin
					u_checker.arm($sformatf("%s_%0d", name_q[i], w), fill_words[w],
						32'hffffffff, 1'b0, 1'b0, 1'b0);
					bus_access(1'b0, addr_q[i] + 32'(w * 4), '0);
				end
			end
			else
				u_checker.note_failure(name_q[i], "unknown operation in pattern file");
		end
	endtask

	// ==================================================
	// Main sequence and watchdog
	// ==================================================

	initial
	begin
		clock = 1'b0;
		i_arst_n = 1'b0;
		bus_request = 1'b0;
		bus_req = '0;
		lfsr_state = LFSR_SEED;
		last_rdata = '0;
		load_done = 1'b0;
		n_lines = 0;
		load_patterns(load_ok);
		if (!load_ok)
		begin
			$display("could not read any pattern from soc_bus_patterns.txt");
			$display("tests failed");
			$finish;
		end
		else
		begin
			load_done = 1'b1;
			repeat (4) @(posedge clock);
			#5;
			i_arst_n = 1'b1;
			for (int i = 0; i < n_lines; i++)
				run_pattern(i);
			@(posedge clock);
			$display("tests run %0d, passed %0d, failed %0d",
				u_checker.pass_count + u_checker.fail_count,
				u_checker.pass_count, u_checker.fail_count);
			if (u_checker.fail_count == 0 && u_checker.pass_count > 0)
				$display("all tests passed");
			else
				$display("tests failed");
			$finish;
		end
	end

	initial
	begin
		wait (load_done);
		#(n_lines * POLL_LIMIT * CLOCK_PERIOD);
		$display("timeout: the bus stopped answering before the patterns were done");
		$display("tests failed");
		$finish;
	end

endmodule

/* vlog.f */
soc_pkg.sv
bus_decode.sv
bus_ram.sv
bus_timer.sv
bus_return.sv
soc_bus_top.sv
tb_bus_checker.sv
tb_soc_bus.sv
